/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Mdir obj_dir
TOP       = tb_cpu_decode
FILELIST  = src.f

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* design/cpu_decode_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_decode_top import cpu_pkg::*; (
	input  logic          clk_i,
	input  logic          rst_n_i,
	input  Bit_t          inst_valid_i,
	input  InstAddr_t     pc_i,
	input  Inst_t         inst_i,
	input  MemAccessReq_t ex_mem_req_i,
	input  RegWriteReq_t  ex_wr_i,
	input  RegWriteReq_t  mem_wr_i,
	input  RegWriteReq_t  wb_wr_i,
	output Bit_t          stall_o,
	output IdExPayload_t  id_ex_o
);

	IfIdPayload_t if_id_d, if_id_q;
	IdExPayload_t id_bundle;
	RegAddr_t     raddr1, raddr2;
	Word_t        rdata1, rdata2;

	assign if_id_d = '{valid: inst_valid_i, pc: pc_i, inst: inst_i};

	// on stall the fetched instruction waits here
	pipe_reg #(.payload_t(IfIdPayload_t)) u_if_id (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.stall_i (stall_o),
		.flush_i (1'b0),
		.d_i     (if_id_d),
		.q_o     (if_id_q)
	);

	cpu_id u_id (
		.if_id_i      (if_id_q),
		.reg1_i       (rdata1),
		.reg2_i       (rdata2),
		.reg_raddr1_o (raddr1),
		.reg_raddr2_o (raddr2),
		.ex_mem_req_i (ex_mem_req_i),
		.ex_wr_i      (ex_wr_i),
		.mem_wr_i     (mem_wr_i),
		.stall_o      (stall_o),
		.id_ex_o      (id_bundle)
	);

	regfile u_regfile (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.wr_i     (wb_wr_i),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	// stall turns into a bubble for execute
	pipe_reg #(.payload_t(IdExPayload_t)) u_id_ex (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.stall_i (1'b0),
		.flush_i (stall_o),
		.d_i     (id_bundle),
		.q_o     (id_ex_o)
	);

endmodule

`default_nettype wire

/* design/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define ZERO_WORD 32'h0000_0000
`define ZERO_REG  5'd0

`endif

/* design/cpu_id.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_id import cpu_pkg::*; (
	input  IfIdPayload_t  if_id_i,
	input  Word_t         reg1_i,
	input  Word_t         reg2_i,
	output RegAddr_t      reg_raddr1_o,
	output RegAddr_t      reg_raddr2_o,
	input  MemAccessReq_t ex_mem_req_i,
	input  RegWriteReq_t  ex_wr_i,
	input  RegWriteReq_t  mem_wr_i,
	output Bit_t          stall_o,
	output IdExPayload_t  id_ex_o
);

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [4:0]  shamt;
	logic [25:0] instr_index;
	RegAddr_t    rs, rt, rd;
	HalfWord_t   immediate;

	InstAddr_t pc_plus4, pc_plus8;
	Word_t     imm_sext, imm_zext, imm_upper, jump_target;

	Oper_t op_i, op_r, op;
	Bit_t  unsigned_imm, is_ld, upper_imm, shift_imm;
	Bit_t  ex_is_load, we_raw, link;
	Word_t imm, fwd1, fwd2;
	RegAddr_t waddr;

	assign opcode      = if_id_i.inst[31:26];
	assign rs          = if_id_i.inst[25:21];
	assign rt          = if_id_i.inst[20:16];
	assign rd          = if_id_i.inst[15:11];
	assign shamt       = if_id_i.inst[10:6];
	assign funct       = if_id_i.inst[5:0];
	assign immediate   = if_id_i.inst[15:0];
	assign instr_index = if_id_i.inst[25:0];

	assign pc_plus4    = if_id_i.pc + 32'd4;
	assign pc_plus8    = if_id_i.pc + 32'd8;
	assign imm_sext    = {{16{immediate[15]}}, immediate};
	assign imm_zext    = {16'h0000, immediate};
	assign imm_upper   = {immediate, 16'h0000};
	assign jump_target = {pc_plus4[31:28], instr_index, 2'b00};

	id_type_i u_type_i (
		.opcode_i       (opcode),
		.op_o           (op_i),
		.unsigned_imm_o (unsigned_imm),
		.is_load_o      (is_ld),
		.upper_imm_o    (upper_imm)
	);

	id_type_r u_type_r (
		.opcode_i    (opcode),
		.funct_i     (funct),
		.op_o        (op_r),
		.shift_imm_o (shift_imm)
	);

	// I-type wins over J/JAL, which wins over SPECIAL
	always_comb begin
		op           = OP_INVALID;
		reg_raddr1_o = `ZERO_REG;
		reg_raddr2_o = `ZERO_REG;
		imm          = `ZERO_WORD;
		we_raw       = 1'b0;
		waddr        = `ZERO_REG;
		link         = 1'b0;
		if (op_i != OP_INVALID) begin
			op           = op_i;
			reg_raddr1_o = rs;
			imm          = upper_imm ? imm_upper : (unsigned_imm ? imm_zext : imm_sext);
			we_raw       = 1'b1;
			waddr        = rt;
		end else if (opcode == OPC_J || opcode == OPC_JAL) begin
			// opcode bit 0 separates JAL from J
			op     = opcode[0] ? OP_JAL : OP_J;
			imm    = jump_target;
			we_raw = opcode[0];
			waddr  = RA_REG;
			link   = 1'b1;
		end else if (op_r != OP_INVALID) begin
			op           = op_r;
			reg_raddr1_o = rs;
			reg_raddr2_o = rt;
			imm          = shift_imm ? {27'd0, shamt} : `ZERO_WORD;
			we_raw       = 1'b1;
			waddr        = rd;
		end
	end

	// $0 first, then EX, then MEM, then the register file
	function automatic Word_t forward(RegAddr_t raddr, Word_t rf_data,
			RegWriteReq_t ex_wr, RegWriteReq_t mem_wr);
		if (raddr == `ZERO_REG)
			return `ZERO_WORD;
		if (ex_wr.we && ex_wr.waddr == raddr)
			return ex_wr.wdata;
		if (mem_wr.we && mem_wr.waddr == raddr)
			return mem_wr.wdata;
		return rf_data;
	endfunction

	assign fwd1 = forward(reg_raddr1_o, reg1_i, ex_wr_i, mem_wr_i);
	assign fwd2 = forward(reg_raddr2_o, reg2_i, ex_wr_i, mem_wr_i);

	// a load in EX has no data yet, so a dependent instruction waits
	assign ex_is_load = ex_mem_req_i.ce && !ex_mem_req_i.we;
	assign stall_o = if_id_i.valid && ex_is_load &&
		((reg_raddr1_o != `ZERO_REG && ex_wr_i.waddr == reg_raddr1_o) ||
		 (reg_raddr2_o != `ZERO_REG && ex_wr_i.waddr == reg_raddr2_o));

	always_comb begin
		id_ex_o.valid     = if_id_i.valid;
		id_ex_o.pc        = if_id_i.pc;
		id_ex_o.op        = op;
		// JAL carries its link value pc+8 as the first operand
		id_ex_o.reg1      = link ? pc_plus8 : fwd1;
		id_ex_o.reg2      = fwd2;
		id_ex_o.imm       = imm;
		// writes to $0 are dropped here so later stages never forward them
		id_ex_o.reg_we    = we_raw && (waddr != `ZERO_REG);
		id_ex_o.reg_waddr = waddr;
		id_ex_o.is_load   = is_ld;
	end

	// the load's destination is taken from the EX write request
	always_comb begin
		if (ex_is_load) begin
			assert (ex_wr_i.we)
				else $error("load in EX without a register write request");
		end
	end

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] Word_t;
	typedef logic [15:0] HalfWord_t;
	typedef logic [31:0] InstAddr_t;
	typedef logic [31:0] Inst_t;
	typedef logic [4:0]  RegAddr_t;
	typedef logic        Bit_t;

	localparam int       REG_COUNT = 32;
	localparam RegAddr_t RA_REG    = 5'd31;

	// primary opcodes
	localparam logic [5:0] OPC_SPECIAL = 6'b000000;
	localparam logic [5:0] OPC_J       = 6'b000010;
	localparam logic [5:0] OPC_JAL     = 6'b000011;
	localparam logic [5:0] OPC_ADDIU   = 6'b001001;
	localparam logic [5:0] OPC_SLTI    = 6'b001010;
	localparam logic [5:0] OPC_ANDI    = 6'b001100;
	localparam logic [5:0] OPC_ORI     = 6'b001101;
	localparam logic [5:0] OPC_XORI    = 6'b001110;
	localparam logic [5:0] OPC_LUI     = 6'b001111;
	localparam logic [5:0] OPC_LW      = 6'b100011;

	// funct codes under OPC_SPECIAL
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;

	typedef enum logic [4:0] {
		OP_INVALID,
		OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW,
		OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLL, OP_SRL,
		OP_J, OP_JAL
	} Oper_t;

	typedef struct packed {
		Bit_t     we;
		RegAddr_t waddr;
		Word_t    wdata;
	} RegWriteReq_t;

	typedef struct packed {
		Bit_t ce;
		Bit_t we;
	} MemAccessReq_t;

	// valid must stay the first field, flush relies on an all-zero payload
	typedef struct packed {
		Bit_t      valid;
		InstAddr_t pc;
		Inst_t     inst;
	} IfIdPayload_t;

	typedef struct packed {
		Bit_t      valid;
		InstAddr_t pc;
		Oper_t     op;
		Word_t     reg1;
		Word_t     reg2;
		Word_t     imm;
		Bit_t      reg_we;
		RegAddr_t  reg_waddr;
		Bit_t      is_load;
	} IdExPayload_t;

endpackage

`default_nettype wire

/* design/id_type_i.sv */
`timescale 1ns/10ps
`default_nettype none

module id_type_i import cpu_pkg::*; (
	input  logic [5:0] opcode_i,
	output Oper_t      op_o,
	output Bit_t       unsigned_imm_o,
	output Bit_t       is_load_o,
	output Bit_t       upper_imm_o
);

	always_comb begin
		op_o           = OP_INVALID;
		unsigned_imm_o = 1'b0;
		is_load_o      = 1'b0;
		upper_imm_o    = 1'b0;
		case (opcode_i)
			OPC_ADDIU: op_o = OP_ADDIU;
			OPC_SLTI:  op_o = OP_SLTI;
			// logical ops take a zero-extended immediate
			OPC_ANDI: begin
				op_o           = OP_ANDI;
				unsigned_imm_o = 1'b1;
			end
			OPC_ORI: begin
				op_o           = OP_ORI;
				unsigned_imm_o = 1'b1;
			end
			OPC_XORI: begin
				op_o           = OP_XORI;
				unsigned_imm_o = 1'b1;
			end
			OPC_LUI: begin
				op_o        = OP_LUI;
				upper_imm_o = 1'b1;
			end
			OPC_LW: begin
				op_o      = OP_LW;
				is_load_o = 1'b1;
			end
			default: op_o = OP_INVALID;
		endcase
	end

endmodule

`default_nettype wire

/* design/id_type_r.sv */
`timescale 1ns/10ps
`default_nettype none

module id_type_r import cpu_pkg::*; (
	input  logic [5:0] opcode_i,
	input  logic [5:0] funct_i,
	output Oper_t      op_o,
	output Bit_t       shift_imm_o
);

	Oper_t funct_op;

	always_comb begin
		case (funct_i)
			FN_ADDU: funct_op = OP_ADDU;
			FN_SUBU: funct_op = OP_SUBU;
			FN_AND:  funct_op = OP_AND;
			FN_OR:   funct_op = OP_OR;
			FN_XOR:  funct_op = OP_XOR;
			FN_NOR:  funct_op = OP_NOR;
			FN_SLT:  funct_op = OP_SLT;
			FN_SLL:  funct_op = OP_SLL;
			FN_SRL:  funct_op = OP_SRL;
			default: funct_op = OP_INVALID;
		endcase
	end

	// only SPECIAL carries a funct field
	assign op_o = (opcode_i == OPC_SPECIAL) ? funct_op : OP_INVALID;

	// shifts by constant take shamt instead of rs
	assign shift_imm_o = (op_o == OP_SLL) || (op_o == OP_SRL);

endmodule

`default_nettype wire

/* design/pipe_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk_i,
	input  logic     rst_n_i,
	input  logic     stall_i,
	input  logic     flush_i,
	input  payload_t d_i,
	output payload_t q_o
);

	// an all-zero payload is a bubble since valid is its first field
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			q_o <= '0;
		end else if (flush_i) begin
			q_o <= '0;
		end else if (!stall_i) begin
			q_o <= d_i;
		end
	end

	// the hazard logic must never ask one stage to hold and drop at once
	assert property (@(posedge clk_i) disable iff (!rst_n_i) !(stall_i && flush_i))
		else $error("pipe_reg stall and flush asserted together");

endmodule

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module regfile import cpu_pkg::*; (
	input  logic         clk_i,
	input  logic         rst_n_i,
	input  RegWriteReq_t wr_i,
	input  RegAddr_t     raddr1_i,
	input  RegAddr_t     raddr2_i,
	output Word_t        rdata1_o,
	output Word_t        rdata2_o
);

	Word_t regs [REG_COUNT];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= `ZERO_WORD;
			end
		end else if (wr_i.we && wr_i.waddr != `ZERO_REG) begin
			regs[wr_i.waddr] <= wr_i.wdata;
		end
	end

	// same-cycle write to the read address is passed straight through
	function automatic Word_t read_port(RegAddr_t raddr, Word_t stored, RegWriteReq_t wr);
		if (raddr == `ZERO_REG)
			return `ZERO_WORD;
		if (wr.we && wr.waddr == raddr)
			return wr.wdata;
		return stored;
	endfunction

	assign rdata1_o = read_port(raddr1_i, regs[raddr1_i], wr_i);
	assign rdata2_o = read_port(raddr2_i, regs[raddr2_i], wr_i);

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/cpu_pkg.sv
design/id_type_i.sv
design/id_type_r.sv
design/cpu_id.sv
design/regfile.sv
design/pipe_reg.sv
design/cpu_decode_top.sv
tests/tb_cpu_decode.sv

/* tests/tb_cpu_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_decode import cpu_pkg::*; ();

	typedef struct packed {
		InstAddr_t     pc;
		Inst_t         inst;
		MemAccessReq_t mreq;
		RegWriteReq_t  ex_wr;
		RegWriteReq_t  mem_wr;
		RegWriteReq_t  wb_wr;
		Bit_t          stall;
		IdExPayload_t  exp;
	} row_t;

	logic          clk_i;
	logic          rst_n_i;
	Bit_t          inst_valid_i;
	InstAddr_t     pc_i;
	Inst_t         inst_i;
	MemAccessReq_t ex_mem_req_i;
	RegWriteReq_t  ex_wr_i;
	RegWriteReq_t  mem_wr_i;
	RegWriteReq_t  wb_wr_i;
	Bit_t          stall_o;
	IdExPayload_t  id_ex_o;

	row_t          rows[$];
	string         names[$];
	MemAccessReq_t side_mreq;
	RegWriteReq_t  side_ex;
	RegWriteReq_t  side_mem;
	RegWriteReq_t  side_wb;
	logic [31:0]   rng_state = 32'h406f5a33;
	bit            table_ready = 1'b0;
	string         cur_name;
	int            row_errors;
	int            passed = 0;
	int            failed = 0;

	cpu_decode_top DUT (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.inst_valid_i (inst_valid_i),
		.pc_i         (pc_i),
		.inst_i       (inst_i),
		.ex_mem_req_i (ex_mem_req_i),
		.ex_wr_i      (ex_wr_i),
		.mem_wr_i     (mem_wr_i),
		.wb_wr_i      (wb_wr_i),
		.stall_o      (stall_o),
		.id_ex_o      (id_ex_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	function automatic Inst_t enc_i(logic [5:0] opc, RegAddr_t rs, RegAddr_t rt, HalfWord_t imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic Inst_t enc_r(RegAddr_t rs, RegAddr_t rt, RegAddr_t rd, logic [4:0] sh,
			logic [5:0] fn);
		return {OPC_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic Inst_t enc_j(logic [5:0] opc, logic [25:0] idx);
		return {opc, idx};
	endfunction

	function automatic Word_t sext(HalfWord_t h);
		return {{16{h[15]}}, h};
	endfunction

	function automatic Word_t zext(HalfWord_t h);
		return {16'h0000, h};
	endfunction

	// target keeps the region of the delay slot address
	function automatic Word_t jump_target(InstAddr_t pc, logic [25:0] idx);
		InstAddr_t p4;
		p4 = pc + 32'd4;
		return {p4[31:28], idx, 2'b00};
	endfunction

	task automatic idle_side();
		side_mreq = '0;
		side_ex   = '0;
		side_mem  = '0;
		side_wb   = '0;
	endtask

	// side inputs go back to idle after every row
	task automatic add_row(string name, InstAddr_t pc, Inst_t inst, Bit_t stall, Bit_t valid,
			Oper_t op, Word_t reg1, Word_t reg2, Word_t imm, Bit_t we, RegAddr_t waddr, Bit_t ld);
		row_t r;
		r.pc            = pc;
		r.inst          = inst;
		r.mreq          = side_mreq;
		r.ex_wr         = side_ex;
		r.mem_wr        = side_mem;
		r.wb_wr         = side_wb;
		r.stall         = stall;
		r.exp.valid     = valid;
		r.exp.pc        = pc;
		r.exp.op        = op;
		r.exp.reg1      = reg1;
		r.exp.reg2      = reg2;
		r.exp.imm       = imm;
		r.exp.reg_we    = we;
		r.exp.reg_waddr = waddr;
		r.exp.is_load   = ld;
		rows.push_back(r);
		names.push_back(name);
		idle_side();
	endtask

	task automatic build_table();
		logic [31:0] r;
		HalfWord_t   h;
		logic [25:0] idx;
		InstAddr_t   pc;
		idle_side();
		add_row("reset_regs_zero", 32'h0040_0000, enc_r(5'd21, 5'd30, 5'd7, 5'd0, FN_ADDU),
			1'b0, 1'b1, OP_ADDU, 32'h0, 32'h0, 32'h0, 1'b1, 5'd7, 1'b0);
		// r1 is written by wb in the very cycle that ID reads it
		side_wb = '{we: 1'b1, waddr: 5'd1, wdata: 32'h1111_1111};
		next_random(r);
		h = r[15:0] | 16'h8000;
		add_row("addiu_neg_imm", 32'h0040_0004, enc_i(OPC_ADDIU, 5'd1, 5'd2, h),
			1'b0, 1'b1, OP_ADDIU, 32'h1111_1111, 32'h0, sext(h), 1'b1, 5'd2, 1'b0);
		side_wb = '{we: 1'b1, waddr: 5'd3, wdata: 32'h3333_3333};
		next_random(r);
		h = r[15:0] | 16'h8000;
		add_row("ori_zext_imm", 32'h0040_0008, enc_i(OPC_ORI, 5'd1, 5'd4, h),
			1'b0, 1'b1, OP_ORI, 32'h1111_1111, 32'h0, zext(h), 1'b1, 5'd4, 1'b0);
		next_random(r);
		h = r[15:0];
		add_row("lui_upper_imm", 32'h0040_000C, enc_i(OPC_LUI, 5'd0, 5'd8, h),
			1'b0, 1'b1, OP_LUI, 32'h0, 32'h0, {h, 16'h0000}, 1'b1, 5'd8, 1'b0);
		next_random(r);
		h = r[15:0];
		add_row("lw_is_load", 32'h0040_0010, enc_i(OPC_LW, 5'd3, 5'd9, h),
			1'b0, 1'b1, OP_LW, 32'h3333_3333, 32'h0, sext(h), 1'b1, 5'd9, 1'b1);
		add_row("addu_two_reads", 32'h0040_0014, enc_r(5'd1, 5'd3, 5'd10, 5'd0, FN_ADDU),
			1'b0, 1'b1, OP_ADDU, 32'h1111_1111, 32'h3333_3333, 32'h0, 1'b1, 5'd10, 1'b0);
		add_row("sll_shamt_imm", 32'h0040_0018, enc_r(5'd0, 5'd3, 5'd11, 5'd5, FN_SLL),
			1'b0, 1'b1, OP_SLL, 32'h0, 32'h3333_3333, 32'd5, 1'b1, 5'd11, 1'b0);
		// link value pc+8 rides in reg1 for both jumps
		next_random(r);
		idx = r[25:0];
		pc = 32'h4000_0100;
		add_row("j_no_write", pc, enc_j(OPC_J, idx), 1'b0, 1'b1, OP_J, pc + 32'd8, 32'h0,
			jump_target(pc, idx), 1'b0, RA_REG, 1'b0);
		next_random(r);
		idx = r[25:0];
		pc = 32'hAFFF_FFFC;
		add_row("jal_link", pc, enc_j(OPC_JAL, idx), 1'b0, 1'b1, OP_JAL, pc + 32'd8, 32'h0,
			jump_target(pc, idx), 1'b1, RA_REG, 1'b0);
		add_row("bad_opcode", 32'h0040_0024, {6'b111111, 26'h155_5555},
			1'b0, 1'b1, OP_INVALID, 32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 1'b0);
		add_row("bad_funct", 32'h0040_0028, enc_r(5'd1, 5'd3, 5'd12, 5'd0, 6'b111111),
			1'b0, 1'b1, OP_INVALID, 32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 1'b0);
		side_ex = '{we: 1'b1, waddr: 5'd1, wdata: 32'hAAAA_0001};
		side_mem = '{we: 1'b1, waddr: 5'd1, wdata: 32'hBBBB_0002};
		add_row("fwd_ex_first", 32'h0040_002C, enc_r(5'd1, 5'd3, 5'd13, 5'd0, FN_ADDU),
			1'b0, 1'b1, OP_ADDU, 32'hAAAA_0001, 32'h3333_3333, 32'h0, 1'b1, 5'd13, 1'b0);
		side_mem = '{we: 1'b1, waddr: 5'd1, wdata: 32'hBBBB_0002};
		add_row("fwd_mem_second", 32'h0040_0030, enc_r(5'd1, 5'd3, 5'd13, 5'd0, FN_ADDU),
			1'b0, 1'b1, OP_ADDU, 32'hBBBB_0002, 32'h3333_3333, 32'h0, 1'b1, 5'd13, 1'b0);
		add_row("fwd_regfile_last", 32'h0040_0034, enc_r(5'd1, 5'd3, 5'd13, 5'd0, FN_ADDU),
			1'b0, 1'b1, OP_ADDU, 32'h1111_1111, 32'h3333_3333, 32'h0, 1'b1, 5'd13, 1'b0);
		side_ex = '{we: 1'b1, waddr: 5'd0, wdata: 32'hDEAD_BEEF};
		side_wb = '{we: 1'b1, waddr: 5'd0, wdata: 32'hCAFE_F00D};
		add_row("zero_src_ignores_fwd", 32'h0040_0038, enc_r(5'd0, 5'd0, 5'd14, 5'd0, FN_ADDU),
			1'b0, 1'b1, OP_ADDU, 32'h0, 32'h0, 32'h0, 1'b1, 5'd14, 1'b0);
		add_row("zero_reg_after_wb", 32'h0040_003C, enc_r(5'd0, 5'd0, 5'd15, 5'd0, FN_ADDU),
			1'b0, 1'b1, OP_ADDU, 32'h0, 32'h0, 32'h0, 1'b1, 5'd15, 1'b0);
		// load in EX targets r1, ADDU waits until the data sits in MEM
		side_mreq = '{ce: 1'b1, we: 1'b0};
		side_ex = '{we: 1'b1, waddr: 5'd1, wdata: 32'h5555_5555};
		add_row("load_use_stall", 32'h0040_0040, enc_r(5'd1, 5'd3, 5'd16, 5'd0, FN_ADDU),
			1'b1, 1'b0, OP_INVALID, 32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 1'b0);
		side_mreq = '{ce: 1'b1, we: 1'b0};
		side_ex = '{we: 1'b1, waddr: 5'd1, wdata: 32'h5555_5555};
		add_row("load_use_hold", 32'h0040_0040, enc_r(5'd1, 5'd3, 5'd16, 5'd0, FN_ADDU),
			1'b1, 1'b0, OP_INVALID, 32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 1'b0);
		side_mem = '{we: 1'b1, waddr: 5'd1, wdata: 32'h7777_7777};
		add_row("load_use_release", 32'h0040_0040, enc_r(5'd1, 5'd3, 5'd16, 5'd0, FN_ADDU),
			1'b0, 1'b1, OP_ADDU, 32'h7777_7777, 32'h3333_3333, 32'h0, 1'b1, 5'd16, 1'b0);
		side_mreq = '{ce: 1'b1, we: 1'b0};
		side_ex = '{we: 1'b1, waddr: 5'd20, wdata: 32'h5555_5555};
		add_row("load_no_match", 32'h0040_0044, enc_r(5'd1, 5'd3, 5'd17, 5'd0, FN_ADDU),
			1'b0, 1'b1, OP_ADDU, 32'h1111_1111, 32'h3333_3333, 32'h0, 1'b1, 5'd17, 1'b0);
	endtask

	task automatic check_word(string sig, logic [31:0] exp, logic [31:0] got);
		if (got !== exp) begin
			$display("** Error: %s: %s expected %h got %h", cur_name, sig, exp, got);
			row_errors++;
		end
	endtask

	task automatic report_test();
		if (row_errors == 0) begin
			passed++;
			$display("PASS %s", cur_name);
		end else begin
			failed++;
			$display("FAIL %s with %0d mismatches", cur_name, row_errors);
		end
	endtask

	task automatic check_row(int i);
		IdExPayload_t e;
		e = rows[i].exp;
		cur_name = names[i];
		row_errors = 0;
		check_word("stall_o", 32'(rows[i].stall), 32'(stall_o));
		check_word("id_ex_o.valid", 32'(e.valid), 32'(id_ex_o.valid));
		// a bubble carries nothing worth comparing
		if (e.valid) begin
			check_word("id_ex_o.pc", e.pc, id_ex_o.pc);
			check_word("id_ex_o.op", 32'(e.op), 32'(id_ex_o.op));
			check_word("id_ex_o.reg1", e.reg1, id_ex_o.reg1);
			check_word("id_ex_o.reg2", e.reg2, id_ex_o.reg2);
			check_word("id_ex_o.imm", e.imm, id_ex_o.imm);
			check_word("id_ex_o.reg_we", 32'(e.reg_we), 32'(id_ex_o.reg_we));
			check_word("id_ex_o.reg_waddr", 32'(e.reg_waddr), 32'(id_ex_o.reg_waddr));
			check_word("id_ex_o.is_load", 32'(e.is_load), 32'(id_ex_o.is_load));
		end
		report_test();
	endtask

	// wb write lands in the same cycle that ID reads its operands
	task automatic apply_row(int i);
		inst_valid_i = 1'b1;
		pc_i         = rows[i].pc;
		inst_i       = rows[i].inst;
		ex_mem_req_i = rows[i].mreq;
		ex_wr_i      = rows[i].ex_wr;
		mem_wr_i     = rows[i].mem_wr;
		wb_wr_i      = '0;
		@(posedge clk_i);
		@(negedge clk_i);
		wb_wr_i = rows[i].wb_wr;
		@(posedge clk_i);
		@(negedge clk_i);
		check_row(i);
	endtask

	// four clock periods per row plus some margin
	initial begin
		wait (table_ready);
		#((rows.size() + 10) * 40);
		$display("watchdog expired before all tests finished");
		$display("Errors found");
		$finish;
	end

	initial begin
		rst_n_i      = 1'b0;
		inst_valid_i = 1'b0;
		pc_i         = '0;
		inst_i       = '0;
		ex_mem_req_i = '0;
		ex_wr_i      = '0;
		mem_wr_i     = '0;
		wb_wr_i      = '0;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;
		cur_name = "reset_state";
		row_errors = 0;
		check_word("stall_o", 32'h0, 32'(stall_o));
		check_word("id_ex_o.valid", 32'h0, 32'(id_ex_o.valid));
		check_word("id_ex_o.reg_we", 32'h0, 32'(id_ex_o.reg_we));
		report_test();
		for (int i = 0; i < rows.size(); i++) begin
			apply_row(i);
		end
		$display("tests: %0d passed: %0d failed: %0d", passed + failed, passed, failed);
		if (failed == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
